/* include/mem_bridge_params.svh */
`ifndef MEM_BRIDGE_PARAMS_SVH
`define MEM_BRIDGE_PARAMS_SVH

// bus and sram widths
`define MB_WORD_W      32
`define MB_RAM_ADDR_W  20
`define MB_BE_W        4

// strobe hold time per sram access, in clocks
`define MB_RAM_WAIT    2

// address map: tag in bits 31..23, region select on bit 22
`define MB_MAP_TAG     9'h100
`define MB_REGION_BIT  22

`endif

/* source/mem_bridge_pkg.sv */
`include "mem_bridge_params.svh"

package mem_bridge_pkg;

    // data word or byte address
    typedef logic [`MB_WORD_W-1:0]     word_t;

    // word address at the sram pins
    typedef logic [`MB_RAM_ADDR_W-1:0] ram_addr_t;

    // byte lanes, active high on apb and active low at the sram
    typedef logic [`MB_BE_W-1:0]       byte_en_t;

    typedef enum logic [1:0] {
        CH_IDLE,
        CH_ACCESS,    // sram strobes asserted
        CH_DONE       // done pulse, result registered
    } chan_state_t;

    typedef enum logic [1:0] {
        AP_IDLE,
        AP_WAIT,      // channel request outstanding
        AP_RESP       // recovery cycle after pready
    } apb_state_t;

endpackage

/* source/base_ram_channel.sv */
`timescale 1ns/1ns
`include "mem_bridge_params.svh"

module base_ram_channel (
    input  logic                      clk_i,
    input  logic                      rst_i,
    // instruction fetch side
    input  logic                      ifu_req_i,
    input  mem_bridge_pkg::word_t     ifu_addr_i,
    output logic                      ifu_resp_o,
    output mem_bridge_pkg::word_t     ifu_rdata_o,
    // data side, from the apb port
    input  logic                      lsu_req_i,
    input  mem_bridge_pkg::ram_addr_t lsu_addr_i,
    input  logic                      lsu_write_i,
    input  mem_bridge_pkg::word_t     lsu_wdata_i,
    input  mem_bridge_pkg::byte_en_t  lsu_be_n_i,
    output logic                      lsu_done_o,
    output mem_bridge_pkg::word_t     lsu_rdata_o,
    // base sram pins
    output mem_bridge_pkg::ram_addr_t base_ram_addr_o,
    output mem_bridge_pkg::word_t     base_ram_wdata_o,
    input  mem_bridge_pkg::word_t     base_ram_rdata_i,
    output mem_bridge_pkg::byte_en_t  base_ram_be_n_o,
    output logic                      base_ram_ce_n_o,
    output logic                      base_ram_oe_n_o,
    output logic                      base_ram_we_n_o
);
    import mem_bridge_pkg::*;

    localparam int CNT_W = $clog2(`MB_RAM_WAIT + 1);

    chan_state_t      state_q;
    chan_state_t      state_d;
    logic [CNT_W-1:0] wait_cnt_q;
    logic             owner_lsu_q;   // 1 = data side owns the access
    logic             write_q;
    ram_addr_t        addr_q;
    word_t            wdata_q;
    byte_en_t         be_n_q;
    word_t            rdata_q;
    logic             grant_lsu;
    logic             grant_ifu;
    logic             last_wait;
    logic             ram_active;

    // data side always wins a tie, fetch waits for the next idle cycle
    assign grant_lsu = lsu_req_i;
    assign grant_ifu = ifu_req_i & ~lsu_req_i;

    assign last_wait  = (wait_cnt_q == CNT_W'(`MB_RAM_WAIT - 1));
    assign ram_active = (state_q == CH_ACCESS);

    always_comb begin
        state_d = state_q;
        case (state_q)
            CH_IDLE: begin
                if (grant_lsu || grant_ifu) begin
                    state_d = CH_ACCESS;
                end
            end
            CH_ACCESS: begin
                if (last_wait) begin
                    state_d = CH_DONE;
                end
            end
            CH_DONE:   state_d = CH_IDLE;
            default:   state_d = CH_IDLE;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q     <= CH_IDLE;
            wait_cnt_q  <= '0;
            owner_lsu_q <= 1'b0;
            write_q     <= 1'b0;
        end else begin
            state_q <= state_d;
            if (state_q == CH_IDLE) begin
                wait_cnt_q <= '0;
                if (grant_lsu) begin
                    owner_lsu_q <= 1'b1;
                    write_q     <= lsu_write_i;
                end else if (grant_ifu) begin
                    owner_lsu_q <= 1'b0;
                    write_q     <= 1'b0;     // fetches only read
                end
            end else if (ram_active) begin
                wait_cnt_q <= wait_cnt_q + CNT_W'(1);
            end
        end
    end

    // address, data and lanes held for the whole access
    always_ff @(posedge clk_i) begin
        if (state_q == CH_IDLE) begin
            if (grant_lsu) begin
                addr_q  <= lsu_addr_i;
                wdata_q <= lsu_wdata_i;
                be_n_q  <= lsu_be_n_i;
            end else if (grant_ifu) begin
                addr_q <= ifu_addr_i[`MB_RAM_ADDR_W+1:2];
                be_n_q <= '0;                // all lanes on
            end
        end
        if (ram_active && last_wait) begin
            rdata_q <= base_ram_rdata_i;     // sample on the last strobe cycle
        end
    end

    assign base_ram_addr_o  = addr_q;
    assign base_ram_wdata_o = wdata_q;
    assign base_ram_be_n_o  = be_n_q;
    assign base_ram_ce_n_o  = ~ram_active;
    assign base_ram_oe_n_o  = ~(ram_active & ~write_q);
    assign base_ram_we_n_o  = ~(ram_active & write_q);

    // done goes back to whoever won the access
    assign lsu_done_o  = (state_q == CH_DONE) & owner_lsu_q;
    assign ifu_resp_o  = (state_q == CH_DONE) & ~owner_lsu_q;
    assign lsu_rdata_o = rdata_q;
    assign ifu_rdata_o = rdata_q;

endmodule

/* source/ext_ram_channel.sv */
`timescale 1ns/1ns
`include "mem_bridge_params.svh"

module ext_ram_channel (
    input  logic                      clk_i,
    input  logic                      rst_i,
    // data side, from the apb port
    input  logic                      lsu_req_i,
    input  mem_bridge_pkg::ram_addr_t lsu_addr_i,
    input  logic                      lsu_write_i,
    input  mem_bridge_pkg::word_t     lsu_wdata_i,
    input  mem_bridge_pkg::byte_en_t  lsu_be_n_i,
    output logic                      lsu_done_o,
    output mem_bridge_pkg::word_t     lsu_rdata_o,
    // ext sram pins
    output mem_bridge_pkg::ram_addr_t ext_ram_addr_o,
    output mem_bridge_pkg::word_t     ext_ram_wdata_o,
    input  mem_bridge_pkg::word_t     ext_ram_rdata_i,
    output mem_bridge_pkg::byte_en_t  ext_ram_be_n_o,
    output logic                      ext_ram_ce_n_o,
    output logic                      ext_ram_oe_n_o,
    output logic                      ext_ram_we_n_o
);
    import mem_bridge_pkg::*;

    localparam int CNT_W = $clog2(`MB_RAM_WAIT + 1);

    chan_state_t      state_q;
    logic [CNT_W-1:0] wait_cnt_q;
    logic             write_q;
    ram_addr_t        addr_q;
    word_t            wdata_q;
    byte_en_t         be_n_q;
    word_t            rdata_q;
    logic             last_wait;
    logic             ram_active;

    assign last_wait  = (wait_cnt_q == CNT_W'(`MB_RAM_WAIT - 1));
    assign ram_active = (state_q == CH_ACCESS);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q    <= CH_IDLE;
            wait_cnt_q <= '0;
            write_q    <= 1'b0;
        end else begin
            case (state_q)
                CH_IDLE: begin
                    wait_cnt_q <= '0;
                    if (lsu_req_i) begin
                        write_q <= lsu_write_i;
                        state_q <= CH_ACCESS;
                    end
                end
                CH_ACCESS: begin
                    wait_cnt_q <= wait_cnt_q + CNT_W'(1);
                    if (last_wait) state_q <= CH_DONE;
                end
                default: state_q <= CH_IDLE;   // CH_DONE lasts one cycle
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == CH_IDLE && lsu_req_i) begin
            addr_q  <= lsu_addr_i;
            wdata_q <= lsu_wdata_i;
            be_n_q  <= lsu_be_n_i;
        end
        if (ram_active && last_wait) begin
            rdata_q <= ext_ram_rdata_i;
        end
    end

    // strobes only while accessing
    assign ext_ram_addr_o  = addr_q;
    assign ext_ram_wdata_o = wdata_q;
    assign ext_ram_be_n_o  = be_n_q;
    assign ext_ram_ce_n_o  = ~ram_active;
    assign ext_ram_oe_n_o  = ~(ram_active & ~write_q);
    assign ext_ram_we_n_o  = ~(ram_active & write_q);

    assign lsu_done_o  = (state_q == CH_DONE);
    assign lsu_rdata_o = rdata_q;

endmodule

/* source/apb_data_port.sv */
`timescale 1ns/1ns
`include "mem_bridge_params.svh"

module apb_data_port (
    input  logic                      clk_i,
    input  logic                      rst_i,
    // apb slave
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  mem_bridge_pkg::word_t     paddr_i,
    input  mem_bridge_pkg::word_t     pwdata_i,
    input  mem_bridge_pkg::byte_en_t  pstrb_i,
    output mem_bridge_pkg::word_t     prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    // requests to the channels
    output logic                      base_req_o,
    output logic                      ext_req_o,
    output mem_bridge_pkg::ram_addr_t req_addr_o,
    output logic                      req_write_o,
    output mem_bridge_pkg::word_t     req_wdata_o,
    output mem_bridge_pkg::byte_en_t  req_be_n_o,
    // channel results
    input  logic                      base_done_i,
    input  logic                      ext_done_i,
    input  mem_bridge_pkg::word_t     base_rdata_i,
    input  mem_bridge_pkg::word_t     ext_rdata_i
);
    import mem_bridge_pkg::*;

    apb_state_t state_q;
    logic       sel_ext_q;     // region of the outstanding request
    logic       access_start;
    logic       tag_ok;
    logic       addr_ext;
    logic       start_ok;
    logic       chan_done;

    // first access cycle of a transfer
    assign access_start = (state_q == AP_IDLE) & psel_i & penable_i;

    assign tag_ok   = (paddr_i[`MB_WORD_W-1:`MB_REGION_BIT+1] == `MB_MAP_TAG);
    assign addr_ext = paddr_i[`MB_REGION_BIT];
    assign start_ok = access_start & tag_ok;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q   <= AP_IDLE;
            sel_ext_q <= 1'b0;
        end else begin
            case (state_q)
                AP_IDLE: begin
                    if (start_ok) begin
                        sel_ext_q <= addr_ext;
                        state_q   <= AP_WAIT;
                    end else if (access_start) begin
                        state_q <= AP_RESP;   // error already answered
                    end
                end
                AP_WAIT: begin
                    if (chan_done) state_q <= AP_RESP;
                end
                default: state_q <= AP_IDLE;  // master is in setup here
            endcase
        end
    end

    // request level from the first access cycle until done
    assign base_req_o = (start_ok & ~addr_ext) | ((state_q == AP_WAIT) & ~sel_ext_q);
    assign ext_req_o  = (start_ok & addr_ext) | ((state_q == AP_WAIT) & sel_ext_q);

    // apb holds address and data stable through the access phase
    assign req_addr_o  = paddr_i[`MB_RAM_ADDR_W+1:2];
    assign req_write_o = pwrite_i;
    assign req_wdata_o = pwdata_i;
    assign req_be_n_o  = pwrite_i ? ~pstrb_i : '0;   // reads use every lane

    // merge, selected channel only
    assign chan_done = sel_ext_q ? ext_done_i : base_done_i;
    assign prdata_o  = sel_ext_q ? ext_rdata_i : base_rdata_i;

    assign pslverr_o = access_start & ~tag_ok;
    assign pready_o  = pslverr_o | ((state_q == AP_WAIT) & chan_done);

endmodule

/* source/mem_bridge_top.sv */
`timescale 1ns/1ns

module mem_bridge_top (
    input  logic                      clk_i,
    input  logic                      rst_i,
    // instruction fetch
    input  logic                      ifu_req_i,
    input  mem_bridge_pkg::word_t     ifu_addr_i,
    output logic                      ifu_resp_o,
    output mem_bridge_pkg::word_t     ifu_rdata_o,
    // apb data port
    input  logic                      psel_i,
    input  logic                      penable_i,
    input  logic                      pwrite_i,
    input  mem_bridge_pkg::word_t     paddr_i,
    input  mem_bridge_pkg::word_t     pwdata_i,
    input  mem_bridge_pkg::byte_en_t  pstrb_i,
    output mem_bridge_pkg::word_t     prdata_o,
    output logic                      pready_o,
    output logic                      pslverr_o,
    // base sram
    output mem_bridge_pkg::ram_addr_t base_ram_addr_o,
    output mem_bridge_pkg::word_t     base_ram_wdata_o,
    input  mem_bridge_pkg::word_t     base_ram_rdata_i,
    output mem_bridge_pkg::byte_en_t  base_ram_be_n_o,
    output logic                      base_ram_ce_n_o,
    output logic                      base_ram_oe_n_o,
    output logic                      base_ram_we_n_o,
    // ext sram
    output mem_bridge_pkg::ram_addr_t ext_ram_addr_o,
    output mem_bridge_pkg::word_t     ext_ram_wdata_o,
    input  mem_bridge_pkg::word_t     ext_ram_rdata_i,
    output mem_bridge_pkg::byte_en_t  ext_ram_be_n_o,
    output logic                      ext_ram_ce_n_o,
    output logic                      ext_ram_oe_n_o,
    output logic                      ext_ram_we_n_o
);
    import mem_bridge_pkg::*;

    // shared request fields, fanned out to both channels
    logic      base_req;
    logic      ext_req;
    ram_addr_t req_addr;
    logic      req_write;
    word_t     req_wdata;
    byte_en_t  req_be_n;
    logic      base_done;
    logic      ext_done;
    word_t     base_rdata;
    word_t     ext_rdata;

    apb_data_port u_apb_port (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .psel_i       (psel_i),
        .penable_i    (penable_i),
        .pwrite_i     (pwrite_i),
        .paddr_i      (paddr_i),
        .pwdata_i     (pwdata_i),
        .pstrb_i      (pstrb_i),
        .prdata_o     (prdata_o),
        .pready_o     (pready_o),
        .pslverr_o    (pslverr_o),
        .base_req_o   (base_req),
        .ext_req_o    (ext_req),
        .req_addr_o   (req_addr),
        .req_write_o  (req_write),
        .req_wdata_o  (req_wdata),
        .req_be_n_o   (req_be_n),
        .base_done_i  (base_done),
        .ext_done_i   (ext_done),
        .base_rdata_i (base_rdata),
        .ext_rdata_i  (ext_rdata)
    );

    base_ram_channel u_base_chan (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .ifu_req_i        (ifu_req_i),
        .ifu_addr_i       (ifu_addr_i),
        .ifu_resp_o       (ifu_resp_o),
        .ifu_rdata_o      (ifu_rdata_o),
        .lsu_req_i        (base_req),
        .lsu_addr_i       (req_addr),
        .lsu_write_i      (req_write),
        .lsu_wdata_i      (req_wdata),
        .lsu_be_n_i       (req_be_n),
        .lsu_done_o       (base_done),
        .lsu_rdata_o      (base_rdata),
        .base_ram_addr_o  (base_ram_addr_o),
        .base_ram_wdata_o (base_ram_wdata_o),
        .base_ram_rdata_i (base_ram_rdata_i),
        .base_ram_be_n_o  (base_ram_be_n_o),
        .base_ram_ce_n_o  (base_ram_ce_n_o),
        .base_ram_oe_n_o  (base_ram_oe_n_o),
        .base_ram_we_n_o  (base_ram_we_n_o)
    );

    ext_ram_channel u_ext_chan (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .lsu_req_i       (ext_req),
        .lsu_addr_i      (req_addr),
        .lsu_write_i     (req_write),
        .lsu_wdata_i     (req_wdata),
        .lsu_be_n_i      (req_be_n),
        .lsu_done_o      (ext_done),
        .lsu_rdata_o     (ext_rdata),
        .ext_ram_addr_o  (ext_ram_addr_o),
        .ext_ram_wdata_o (ext_ram_wdata_o),
        .ext_ram_rdata_i (ext_ram_rdata_i),
        .ext_ram_be_n_o  (ext_ram_be_n_o),
        .ext_ram_ce_n_o  (ext_ram_ce_n_o),
        .ext_ram_oe_n_o  (ext_ram_oe_n_o),
        .ext_ram_we_n_o  (ext_ram_we_n_o)
    );

endmodule

/* tests/tb_mem_bridge.sv */
`timescale 1ns/1ns

module tb_mem_bridge;
    import mem_bridge_pkg::*;

    localparam int MEM_WORDS = 1024;
    localparam int MAX_OPS   = 64;

    logic      clk_i = 1'b0;
    logic      rst_i;
    logic      ifu_req_i;
    word_t     ifu_addr_i;
    logic      ifu_resp_o;
    word_t     ifu_rdata_o;
    logic      psel_i;
    logic      penable_i;
    logic      pwrite_i;
    word_t     paddr_i;
    word_t     pwdata_i;
    byte_en_t  pstrb_i;
    word_t     prdata_o;
    logic      pready_o;
    logic      pslverr_o;
    ram_addr_t base_ram_addr_o;
    word_t     base_ram_wdata_o;
    word_t     base_ram_rdata_i;
    byte_en_t  base_ram_be_n_o;
    logic      base_ram_ce_n_o;
    logic      base_ram_oe_n_o;
    logic      base_ram_we_n_o;
    ram_addr_t ext_ram_addr_o;
    word_t     ext_ram_wdata_o;
    word_t     ext_ram_rdata_i;
    byte_en_t  ext_ram_be_n_o;
    logic      ext_ram_ce_n_o;
    logic      ext_ram_oe_n_o;
    logic      ext_ram_we_n_o;

    word_t     base_mem [MEM_WORDS];
    word_t     ext_mem [MEM_WORDS];
    int        cycle_count = 0;
    int        cycle_limit = 0;
    int        test_errors = 0;
    int        pass_count = 0;
    int        fail_count = 0;
    logic      watch_ce = 1'b0;
    logic      ce_seen = 1'b0;   // any sram selected while watching

    mem_bridge_top uut (.*);

    always #20 clk_i = ~clk_i;

    // async sram read path gated by ce_n and oe_n
    assign base_ram_rdata_i = (!base_ram_ce_n_o && !base_ram_oe_n_o) ?
                              base_mem[base_ram_addr_o[9:0]] : 'x;
    assign ext_ram_rdata_i  = (!ext_ram_ce_n_o && !ext_ram_oe_n_o) ?
                              ext_mem[ext_ram_addr_o[9:0]] : 'x;

    always @(posedge clk_i) begin
        for (int b = 0; b < 4; b++) begin
            if (!base_ram_ce_n_o && !base_ram_we_n_o && !base_ram_be_n_o[b])
                base_mem[base_ram_addr_o[9:0]][8*b +: 8] <= base_ram_wdata_o[8*b +: 8];
            if (!ext_ram_ce_n_o && !ext_ram_we_n_o && !ext_ram_be_n_o[b])
                ext_mem[ext_ram_addr_o[9:0]][8*b +: 8] <= ext_ram_wdata_o[8*b +: 8];
        end
    end

    always @(negedge clk_i) begin
        if (watch_ce && (!base_ram_ce_n_o || !ext_ram_ce_n_o)) ce_seen = 1'b1;
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("run stopped, no end reached within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic record_result(input int num, input string what);
        if (test_errors == 0) begin
            $display("test %0d %s ok", num, what);
            pass_count++;
        end else begin
            $display("test %0d %s failed with %0d errors", num, what, test_errors);
            fail_count++;
        end
        test_errors = 0;
    endtask

    // setup cycle, then access cycles until pready
    task automatic apb_transfer(input logic wr, input word_t addr, input word_t wdata,
                                input byte_en_t strb, output word_t rdata,
                                output logic err, output int waits);
        waits = 0;
        @(posedge clk_i);
        psel_i    <= 1'b1;
        penable_i <= 1'b0;
        pwrite_i  <= wr;
        paddr_i   <= addr;
        pwdata_i  <= wdata;
        pstrb_i   <= strb;
        @(posedge clk_i);
        penable_i <= 1'b1;
        do begin
            @(negedge clk_i);
            waits++;
        end while (!pready_o);
        rdata = prdata_o;
        err   = pslverr_o;
        @(posedge clk_i);
        psel_i    <= 1'b0;
        penable_i <= 1'b0;
    endtask

    task automatic fetch_word(input word_t addr, output word_t rdata);
        @(posedge clk_i);
        ifu_req_i  <= 1'b1;
        ifu_addr_i <= addr;
        do begin
            @(negedge clk_i);
        end while (!ifu_resp_o);
        rdata = ifu_rdata_o;
        @(posedge clk_i);
        ifu_req_i <= 1'b0;          // held until the response
    endtask

    initial begin
        int               fd;
        int               code;
        int               n_ops;
        int               delay;
        int               waits;
        byte              op;
        byte              op_list [MAX_OPS];
        word_t            addr_list [MAX_OPS];
        word_t            data_list [MAX_OPS];
        byte_en_t         strb_list [MAX_OPS];
        word_t            exp_list [MAX_OPS];
        word_t            rd;
        word_t            fetched;
        logic             err;
        logic [8*128-1:0] skip_line;

        rst_i      = 1'b1;
        ifu_req_i  = 1'b0;
        ifu_addr_i = '0;
        psel_i     = 1'b0;
        penable_i  = 1'b0;
        pwrite_i   = 1'b0;
        paddr_i    = '0;
        pwdata_i   = '0;
        pstrb_i    = '0;
        delay      = $urandom(53364);
        n_ops      = 0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            base_mem[i] = 32'hb000_0000 | i;
            ext_mem[i]  = 32'he000_0000 | i;
        end

        fd = $fopen("tests/mem_bridge_stimulus.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/mem_bridge_stimulus.txt");
            fail_count++;
        end else begin
            while (n_ops < MAX_OPS) begin
                code = $fscanf(fd, " %c", op);
                if (code != 1) break;
                if (op == "#") begin
                    code = $fgets(skip_line, fd);   // column notes
                end else begin
                    op_list[n_ops] = op;
                    code = $fscanf(fd, "%h %h %h %h", addr_list[n_ops], data_list[n_ops],
                                   strb_list[n_ops], exp_list[n_ops]);
                    if (code != 4) begin
                        $display("stimulus entry %0d has missing fields", n_ops + 1);
                        fail_count++;
                        break;
                    end
                    n_ops++;
                end
            end
            $fclose(fd);
        end
        cycle_limit = n_ops * 32;

        repeat (3) @(posedge clk_i);
        rst_i <= 1'b0;
        @(negedge clk_i);
        check_flag("base_ram_ce_n_o", base_ram_ce_n_o, 1'b1);
        check_flag("base_ram_oe_n_o", base_ram_oe_n_o, 1'b1);
        check_flag("base_ram_we_n_o", base_ram_we_n_o, 1'b1);
        check_flag("ext_ram_ce_n_o", ext_ram_ce_n_o, 1'b1);
        check_flag("ext_ram_oe_n_o", ext_ram_oe_n_o, 1'b1);
        check_flag("ext_ram_we_n_o", ext_ram_we_n_o, 1'b1);
        check_flag("pready_o", pready_o, 1'b0);
        check_flag("ifu_resp_o", ifu_resp_o, 1'b0);
        record_result(0, "reset state");

        for (int t = 0; t < n_ops; t++) begin
            case (op_list[t])
                "W": begin
                    apb_transfer(1'b1, addr_list[t], data_list[t], strb_list[t], rd, err, waits);
                    check_flag("pslverr_o", err, 1'b0);
                end
                "R": begin
                    apb_transfer(1'b0, addr_list[t], '0, '0, rd, err, waits);
                    check_flag("pslverr_o", err, 1'b0);
                    check_word("prdata_o", rd, exp_list[t]);
                end
                "F": begin
                    fetch_word(addr_list[t], rd);
                    check_word("ifu_rdata_o", rd, exp_list[t]);
                end
                "C": begin
                    delay = $urandom % 4;
                    fork
                        apb_transfer(1'b0, addr_list[t], '0, '0, rd, err, waits);
                        begin
                            repeat (delay) @(posedge clk_i);
                            fetch_word(addr_list[t] + 32'h4, fetched);
                        end
                    join
                    check_flag("pslverr_o", err, 1'b0);
                    check_word("prdata_o", rd, exp_list[t]);
                    check_word("ifu_rdata_o", fetched, data_list[t]);
                end
                "E": begin
                    ce_seen  = 1'b0;
                    watch_ce = 1'b1;
                    apb_transfer(1'b1, addr_list[t], data_list[t], strb_list[t], rd, err, waits);
                    repeat (2) @(negedge clk_i);   // a stray request would strobe ce_n by now
                    watch_ce = 1'b0;
                    check_flag("pslverr_o", err, 1'b1);
                    check_flag("pready_o on first access cycle", waits == 1, 1'b1);
                    check_flag("sram ce_n asserted", ce_seen, 1'b0);
                end
                default: begin
                    $display("stimulus op %c is not a known operation", op_list[t]);
                    test_errors++;
                end
            endcase
            record_result(t + 1, $sformatf("op %c", op_list[t]));
        end

        $display("tests passed %0d, failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* mem_bridge.f */
+incdir+include
source/mem_bridge_pkg.sv
source/base_ram_channel.sv
source/ext_ram_channel.sv
source/apb_data_port.sv
source/mem_bridge_top.sv
tests/tb_mem_bridge.sv

/* tests/mem_bridge_stimulus.txt */
# op addr data strb exp, all hex. W write, R read, F fetch, E out-of-map write
# C reads addr on apb while fetching addr+4, data is the fetch word, exp the apb word
W 80400000 12345678 f 00000000
R 80400000 00000000 0 12345678
W 80400020 11223344 f 00000000
W 80400020 aabbccdd 5 00000000
R 80400020 00000000 0 11bb33dd
W 80000040 55667788 f 00000000
W 80000040 99aabbcc c 00000000
R 80000040 00000000 0 99aa7788
W 80000100 00000013 f 00000000
F 80000100 00000000 0 00000013
F 80000200 00000000 0 b0000080
W 80000300 0badc0de f 00000000
W 80000304 600dcafe f 00000000
C 80000300 600dcafe 0 0badc0de
C 80000304 b00000c2 0 600dcafe
C 80000010 b0000005 0 b0000004
E 00400010 deadbeef f 00000000
R 80400010 00000000 0 e0000004
E 81400020 deadbeef f 00000000
R 80400020 00000000 0 11bb33dd
E 00000040 deadbeef f 00000000
R 80000040 00000000 0 99aa7788
